/* lsu_tcm.f */
rtl/lsu_pkg.sv
rtl/dtcm_bank_if.sv
rtl/lsu_bank_steer.sv
rtl/dtcm_bank.sv
rtl/lsu_load_align.sv
rtl/lsu_tcm.sv
verification/lsu_tcm_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the lsu_tcm testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module lsu_tcm_tb -Mdir obj_dir -o lsu_tcm_sim \
	-f lsu_tcm.f > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/lsu_tcm_sim > sim.log 2>&1 ; cat sim.log

grep -qx "STATUS: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* verification/lsu_tcm_tb.sv */
/*
 * Load/store unit testbench
 * Directed tests and a random back-to-back mix against a byte-array model
 */
`timescale 1ns/1ns
`default_nettype none

module lsu_tcm_tb;
	import lsu_pkg::*;

	localparam int ROW_AW     = 10;
	localparam int MEM_BYTES  = BANK_COUNT * (2 ** ROW_AW) * BANK_MASK_W;
	localparam int WB_TIMEOUT = 20;
	localparam int DRIVE_DLY  = 1;

	logic                CLK;
	logic                reset;
	logic                issue_valid;
	lsu_op_e             issue_op;
	logic [XLEN-1:0]     issue_addr;
	logic [XLEN-1:0]     issue_wdata;
	logic [RD_TAG_W-1:0] issue_rd;
	logic                flush;
	logic                wb_valid;
	logic [XLEN-1:0]     wb_data;
	logic [RD_TAG_W-1:0] wb_rd;

	// Byte image of both banks, linear in byte address
	logic [7:0]          model [MEM_BYTES];
	int                  errors;
	int                  checks;
	logic [RD_TAG_W-1:0] tag_ctr;

	// Expected writebacks of the random mix, in issue order
	logic [XLEN-1:0]     exp_data_q [$];
	logic [RD_TAG_W-1:0] exp_tag_q [$];
	lsu_op_e             exp_op_q [$];
	lsu_op_e             op_by_tag [2 ** RD_TAG_W];

	lsu_tcm #(
		.ROW_AW (ROW_AW)
	) UUT (
		.CLK         (CLK),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_addr  (issue_addr),
		.issue_wdata (issue_wdata),
		.issue_rd    (issue_rd),
		.flush       (flush),
		.wb_valid    (wb_valid),
		.wb_data     (wb_data),
		.wb_rd       (wb_rd)
	);

	always #5 CLK = ~CLK;

	// Access width in bytes, zero for NOP
	function automatic int op_bytes(lsu_op_e op);
		case (op)
			LSU_LB, LSU_LBU, LSU_SB: op_bytes = 1;
			LSU_LH, LSU_LHU, LSU_SH: op_bytes = 2;
			LSU_LW, LSU_LWU, LSU_SW: op_bytes = 4;
			LSU_LD, LSU_SD:          op_bytes = 8;
			default:                 op_bytes = 0;
		endcase
	endfunction

	function automatic logic is_store_op(lsu_op_e op);
		case (op)
			LSU_SB, LSU_SH, LSU_SW, LSU_SD: is_store_op = 1'b1;
			default:                        is_store_op = 1'b0;
		endcase
	endfunction

	// Byte k of an access, wrapping over the whole bank space
	function automatic int model_index(logic [XLEN-1:0] addr, int k);
		logic [XLEN-1:0] a;
		a = addr + XLEN'(k);
		model_index = int'(a[ROW_AW+3:0]);
	endfunction

	// Loads leave the model untouched
	function automatic void model_store(lsu_op_e op, logic [XLEN-1:0] addr,
	                                    logic [XLEN-1:0] data);
		if (is_store_op(op)) begin
			for (int k = 0; k < op_bytes(op); k++) begin
				model[model_index(addr, k)] = data[k*8 +: 8];
			end
		end
	endfunction

	// Expected result, zero for stores and NOP
	function automatic logic [XLEN-1:0] model_load(lsu_op_e op, logic [XLEN-1:0] addr);
		logic [XLEN-1:0] raw;
		int              n;
		n   = op_bytes(op);
		raw = '0;
		if (!is_store_op(op)) begin
			for (int k = 0; k < n; k++) begin
				raw[k*8 +: 8] = model[model_index(addr, k)];
			end
			// Sign extension for the signed narrow loads
			if ((op == LSU_LB || op == LSU_LH || op == LSU_LW) && raw[n*8-1]) begin
				raw = raw | ({XLEN{1'b1}} << (n * 8));
			end
		end
		model_load = raw;
	endfunction

	task automatic check_data(input string name, input logic [XLEN-1:0] exp,
	                          input logic [XLEN-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_tag(input string name, input logic [RD_TAG_W-1:0] exp,
	                         input logic [RD_TAG_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_op(input string name, input lsu_op_e exp, input lsu_op_e act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %s actual %s", $time, name,
			         exp.name(), act.name());
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic idle_inputs();
		issue_valid = 1'b0;
		issue_op    = LSU_NOP;
		issue_addr  = '0;
		issue_wdata = '0;
		issue_rd    = '0;
		flush       = 1'b0;
	endtask

	// One instruction for one cycle, returns just after the next edge
	task automatic issue_op_task(input lsu_op_e op, input logic [XLEN-1:0] addr,
	                             input logic [XLEN-1:0] wdata,
	                             input logic [RD_TAG_W-1:0] rd, input logic fl);
		issue_valid = 1'b1;
		issue_op    = op;
		issue_addr  = addr;
		issue_wdata = wdata;
		issue_rd    = rd;
		flush       = fl;
		@(posedge CLK);
		#(DRIVE_DLY);
		idle_inputs();
	endtask

	task automatic wait_wb(output int waited);
		waited = 0;
		while (!wb_valid && waited < WB_TIMEOUT) begin
			@(posedge CLK);
			#(DRIVE_DLY);
			waited++;
		end
		if (!wb_valid) begin
			$display("Timeout: no writeback strobe within %0d cycles", WB_TIMEOUT);
			$display("STATUS: FAIL");
			$finish;
		end
	endtask

	// Issue, check the writeback one cycle later, then an idle cycle
	task automatic run_access(input lsu_op_e op, input logic [XLEN-1:0] addr,
	                          input logic [XLEN-1:0] wdata);
		logic [XLEN-1:0]     exp;
		logic [RD_TAG_W-1:0] rd;
		int                  waited;
		rd      = tag_ctr;
		tag_ctr = tag_ctr + RD_TAG_W'(1);
		exp     = model_load(op, addr);
		model_store(op, addr, wdata);
		issue_op_task(op, addr, wdata, rd, 1'b0);
		wait_wb(waited);
		if (waited != 0) begin
			errors++;
			$display("Writeback of %s came %0d cycles late", op.name(), waited);
		end
		check_data("wb_data", exp, wb_data);
		check_tag("wb_rd", rd, wb_rd);
		@(posedge CLK);
		#(DRIVE_DLY);
		check_bit("wb_valid", 1'b0, wb_valid);
	endtask

	// Doubleword fill, pattern built from the full address
	task automatic fill_region(input logic [XLEN-1:0] base, input int dwords);
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] pattern;
		for (int d = 0; d < dwords; d++) begin
			addr    = base + XLEN'(d * 8);
			pattern = {~addr[31:0], addr[31:0]} ^ 64'h9e37_79b9_7f4a_7c15 ^ (addr << 17);
			run_access(LSU_SD, addr, pattern);
		end
	endtask

	task automatic reset_and_aligned();
		for (int c = 0; c < 4; c++) begin
			check_bit("wb_valid", 1'b0, wb_valid);
			@(posedge CLK);
			#(DRIVE_DLY);
		end
		run_access(LSU_SD, 64'h100, 64'h0123_4567_89ab_cdef);
		run_access(LSU_LD, 64'h100, '0);
		// Odd doubleword, top bit set
		run_access(LSU_SD, 64'h108, 64'hfedc_ba98_7654_3210);
		run_access(LSU_LD, 64'h108, '0);
	endtask

	task automatic narrow_extend();
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] wd;
		for (int off = 0; off < 8; off++) begin
			// Upper store data bits are garbage that must not land
			a         = 64'h40 + XLEN'(off);
			wd        = {$urandom, $urandom};
			wd[7:0]   = 8'h70 + 8'(off * 16);
			run_access(LSU_SB, a, wd);
			run_access(LSU_LB, a, '0);
			run_access(LSU_LBU, a, '0);
			a         = 64'h50 + XLEN'(off);
			wd        = {$urandom, $urandom};
			wd[15:0]  = (off % 2 == 1) ? 16'hfe21 ^ 16'(off) : 16'h1234 + 16'(off);
			run_access(LSU_SH, a, wd);
			run_access(LSU_LH, a, '0);
			run_access(LSU_LHU, a, '0);
		end
		for (int off = 0; off < 5; off++) begin
			a        = 64'h28 + XLEN'(off);
			wd       = {$urandom, $urandom};
			wd[31:0] = (off % 2 == 1) ? 32'h8765_4321 + 32'(off) : 32'h0bad_f00d + 32'(off);
			run_access(LSU_SW, a, wd);
			run_access(LSU_LW, a, '0);
			run_access(LSU_LWU, a, '0);
		end
	endtask

	task automatic cross_boundary();
		logic [XLEN-1:0] base;
		for (int side = 0; side < 2; side++) begin
			// Even start doubleword first, then odd
			base = 64'h60 + XLEN'(side * 8);
			run_access(LSU_SW, base + 64'd6, 64'h1111_2222_89ab_cdef);
			run_access(LSU_LW, base + 64'd6, '0);
			run_access(LSU_LWU, base + 64'd6, '0);
			run_access(LSU_SD, base + 64'd3, {$urandom, $urandom});
			run_access(LSU_LD, base + 64'd3, '0);
			run_access(LSU_LH, base + 64'd7, '0);
			run_access(LSU_LD, base, '0);
			run_access(LSU_LD, base + 64'd8, '0);
		end
	endtask

	task automatic mask_isolation();
		for (int d = 0; d < 4; d++) begin
			run_access(LSU_SD, 64'h80 + XLEN'(d * 8), 64'hffff_ffff_ffff_ffff);
		end
		run_access(LSU_SB, 64'h83, 64'h0);
		run_access(LSU_SH, 64'h8e, 64'h0);
		run_access(LSU_SW, 64'h95, 64'h0);
		run_access(LSU_SH, 64'h9f, 64'h0);
		for (int d = 0; d < 5; d++) begin
			run_access(LSU_LD, 64'h80 + XLEN'(d * 8), '0);
		end
	endtask

	task automatic flush_cases();
		// Killed load leaves no strobe
		issue_op_task(LSU_LD, 64'h100, '0, 7'h55, 1'b1);
		check_bit("wb_valid", 1'b0, wb_valid);
		// Killed store still writes
		model_store(LSU_SD, 64'h118, 64'h5a5a_a5a5_c3c3_3c3c);
		issue_op_task(LSU_SD, 64'h118, 64'h5a5a_a5a5_c3c3_3c3c, 7'h56, 1'b1);
		check_bit("wb_valid", 1'b0, wb_valid);
		run_access(LSU_LD, 64'h118, '0);
		run_access(LSU_SW, 64'h11c, 64'hdead_beef_dead_beef);
		run_access(LSU_LD, 64'h118, '0);
	endtask

	task automatic check_in_order_wb();
		logic [XLEN-1:0]     exp_d;
		logic [RD_TAG_W-1:0] exp_t;
		lsu_op_e             exp_o;
		check_bit("wb_valid", 1'b1, wb_valid);
		if (exp_data_q.size() == 0) begin
			errors++;
			$display("Writeback with no instruction outstanding at %0t", $time);
		end else begin
			exp_d = exp_data_q.pop_front();
			exp_t = exp_tag_q.pop_front();
			exp_o = exp_op_q.pop_front();
			check_data("wb_data", exp_d, wb_data);
			check_tag("wb_rd", exp_t, wb_rd);
			check_op("opcode of wb_rd", exp_o, op_by_tag[wb_rd]);
		end
	endtask

	// One instruction per cycle, no gaps
	task automatic random_mix();
		lsu_op_e             op;
		logic [XLEN-1:0]     a;
		logic [XLEN-1:0]     wd;
		logic [RD_TAG_W-1:0] tag;
		for (int i = 0; i < 200; i++) begin
			if (i > 0) begin
				check_in_order_wb();
			end
			op  = lsu_op_e'(4'(1 + ($urandom % 11)));
			a   = 64'h180 + XLEN'($urandom % 64);
			wd  = {$urandom, $urandom};
			tag = RD_TAG_W'(i);
			exp_data_q.push_back(model_load(op, a));
			exp_tag_q.push_back(tag);
			exp_op_q.push_back(op);
			op_by_tag[tag] = op;
			model_store(op, a, wd);
			issue_valid = 1'b1;
			issue_op    = op;
			issue_addr  = a;
			issue_wdata = wd;
			issue_rd    = tag;
			@(posedge CLK);
			#(DRIVE_DLY);
		end
		check_in_order_wb();
		idle_inputs();
		@(posedge CLK);
		#(DRIVE_DLY);
		check_bit("wb_valid", 1'b0, wb_valid);
	endtask

	initial begin
		void'($urandom(32'h39d3));
		errors  = 0;
		checks  = 0;
		tag_ctr = '0;
		CLK     = 1'b0;
		reset   = 1'b1;
		idle_inputs();
		repeat (3) @(posedge CLK);
		#(DRIVE_DLY);
		reset = 1'b0;

		reset_and_aligned();
		// Known contents below 0x200 before any narrow or unaligned load
		fill_region(64'h0, 64);
		narrow_extend();
		cross_boundary();
		mask_isolation();
		flush_cases();
		random_mix();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/lsu_tcm.sv */
/*
 * Load/store unit with data TCM
 * One memory instruction per cycle over two interleaved 64-bit banks,
 * writeback one cycle after issue
 */
`timescale 1ns/1ns
`default_nettype none

module lsu_tcm #(
	parameter int ROW_AW = 10
) (
	input  wire logic                          CLK,
	input  wire logic                          reset,

	// Issue side
	input  wire logic                          issue_valid,
	input  wire lsu_pkg::lsu_op_e              issue_op,
	input  wire logic [lsu_pkg::XLEN-1:0]      issue_addr,
	input  wire logic [lsu_pkg::XLEN-1:0]      issue_wdata,
	input  wire logic [lsu_pkg::RD_TAG_W-1:0]  issue_rd,
	input  wire logic                          flush,

	// Writeback side
	output logic                               wb_valid,
	output logic [lsu_pkg::XLEN-1:0]           wb_data,
	output logic [lsu_pkg::RD_TAG_W-1:0]       wb_rd
);
	import lsu_pkg::*;

	// Index 0 even bank, index 1 odd bank
	dtcm_bank_if #(.ROW_AW(ROW_AW)) bank_bus [BANK_COUNT] ();

	// Address split, masks and store data
	lsu_bank_steer #(
		.ROW_AW (ROW_AW)
	) u_steer (
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_addr  (issue_addr),
		.issue_wdata (issue_wdata),
		.banks       (bank_bus)
	);

	// Bank storage
	generate
		for (genvar i = 0; i < BANK_COUNT; i++) begin : g_bank
			dtcm_bank #(
				.ROW_AW (ROW_AW)
			) u_bank (
				.CLK  (CLK),
				.port (bank_bus[i])
			);
		end
	endgenerate

	// Result extraction and writeback strobe
	lsu_load_align u_align (
		.CLK         (CLK),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue_op    (issue_op),
		.issue_addr  (issue_addr),
		.issue_rd    (issue_rd),
		.flush       (flush),
		.banks       (bank_bus),
		.wb_valid    (wb_valid),
		.wb_data     (wb_data),
		.wb_rd       (wb_rd)
	);

endmodule

`default_nettype wire

/* rtl/lsu_load_align.sv */
/*
 * Load aligner and writeback
 * Holds issue attributes for one cycle, merges bank reads into a
 * 16-byte window and extracts the sign- or zero-extended result
 */
`timescale 1ns/1ns
`default_nettype none

module lsu_load_align (
	input  wire logic                          CLK,
	input  wire logic                          reset,
	input  wire logic                          issue_valid,
	input  wire lsu_pkg::lsu_op_e              issue_op,
	input  wire logic [lsu_pkg::XLEN-1:0]      issue_addr,
	input  wire logic [lsu_pkg::RD_TAG_W-1:0]  issue_rd,
	input  wire logic                          flush,
	dtcm_bank_if.reader                        banks [lsu_pkg::BANK_COUNT],
	output logic                               wb_valid,
	output logic [lsu_pkg::XLEN-1:0]           wb_data,
	output logic [lsu_pkg::RD_TAG_W-1:0]       wb_rd
);
	import lsu_pkg::*;

	// Access width of a load, none for stores and NOP
	typedef enum logic [2:0] {
		SZ_NONE,
		SZ_BYTE,
		SZ_HALF,
		SZ_WORD,
		SZ_DOUBLE
	} size_e;

	size_e               size_d;
	size_e               size_q;
	logic                unsigned_q;
	logic [2:0]          offset_q;
	logic                odd_q;
	logic [RD_TAG_W-1:0] rd_q;
	logic                valid_q;

	logic [2*BANK_DW-1:0] window;
	logic [2*BANK_DW-1:0] win_shift;
	logic [7:0]           ld_b;
	logic [15:0]          ld_h;
	logic [31:0]          ld_w;
	logic [63:0]          ld_d;

	// Opcode to size class
	always_comb begin
		case (issue_op)
			LSU_LB, LSU_LBU: size_d = SZ_BYTE;
			LSU_LH, LSU_LHU: size_d = SZ_HALF;
			LSU_LW, LSU_LWU: size_d = SZ_WORD;
			LSU_LD:          size_d = SZ_DOUBLE;
			default:         size_d = SZ_NONE;
		endcase
	end

	// Control state
	always_ff @(posedge CLK) begin
		if (reset) begin
			valid_q <= 1'b0;
			size_q  <= SZ_NONE;
		end else begin
			// Flush kills the writeback only
			valid_q <= issue_valid && !flush;
			size_q  <= size_d;
		end
	end

	// Payload captured alongside the bank read
	always_ff @(posedge CLK) begin
		unsigned_q <= op_is_unsigned(issue_op);
		offset_q   <= issue_addr[2:0];
		odd_q      <= issue_addr[3];
		rd_q       <= issue_rd;
	end

	// Lower doubleword first in address order
	assign window = odd_q ? {banks[0].rdata, banks[1].rdata}
	                      : {banks[1].rdata, banks[0].rdata};

	// First accessed byte down to bit 0
	assign win_shift = window >> {offset_q, 3'b000};

	assign ld_b = win_shift[7:0];
	assign ld_h = win_shift[15:0];
	assign ld_w = win_shift[31:0];
	assign ld_d = win_shift[63:0];

	// Extension by size and sign
	always_comb begin
		case (size_q)
			SZ_BYTE:   wb_data = unsigned_q ? {{(XLEN-8){1'b0}}, ld_b}
			                                : {{(XLEN-8){ld_b[7]}}, ld_b};
			SZ_HALF:   wb_data = unsigned_q ? {{(XLEN-16){1'b0}}, ld_h}
			                                : {{(XLEN-16){ld_h[15]}}, ld_h};
			SZ_WORD:   wb_data = unsigned_q ? {{(XLEN-32){1'b0}}, ld_w}
			                                : {{(XLEN-32){ld_w[31]}}, ld_w};
			SZ_DOUBLE: wb_data = ld_d;
			// Stores and NOP return zero
			default:   wb_data = '0;
		endcase
	end

	assign wb_valid = valid_q;
	assign wb_rd    = rd_q;

endmodule

`default_nettype wire

/* rtl/dtcm_bank.sv */
/*
 * DTCM bank
 * One 64-bit wide RAM bank, byte-masked write, registered read
 */
`timescale 1ns/1ns
`default_nettype none

module dtcm_bank #(
	parameter int ROW_AW = 10
) (
	input wire logic CLK,
	dtcm_bank_if.bank port
);
	import lsu_pkg::*;

	localparam int ROWS = 2 ** ROW_AW;

	// Storage, no reset on contents
	logic [BANK_DW-1:0] mem [ROWS];

	// Byte lane writes
	always_ff @(posedge CLK) begin
		if (port.wen) begin
			for (int lane = 0; lane < BANK_MASK_W; lane++) begin
				if (port.wmask[lane]) begin
					mem[port.addr][lane*8 +: 8] <= port.wdata[lane*8 +: 8];
				end
			end
		end
	end

	// Read every cycle
	// Same-row write in this cycle gives the old row
	always_ff @(posedge CLK) begin
		port.rdata <= mem[port.addr];
	end

endmodule

`default_nettype wire

/* rtl/lsu_bank_steer.sv */
/*
 * Bank steer
 * Splits one access over the even and odd banks: row addresses,
 * byte masks and shifted store data, all in the issue cycle
 */
`timescale 1ns/1ns
`default_nettype none

module lsu_bank_steer #(
	parameter int ROW_AW = 10
) (
	input  wire logic                      issue_valid,
	input  wire lsu_pkg::lsu_op_e          issue_op,
	input  wire logic [lsu_pkg::XLEN-1:0]  issue_addr,
	input  wire logic [lsu_pkg::XLEN-1:0]  issue_wdata,
	dtcm_bank_if.steer                     banks [lsu_pkg::BANK_COUNT]
);
	import lsu_pkg::*;

	logic [2:0]               offset;
	logic                     odd;
	logic [XLEN-1:0]          addr_next;
	logic [ROW_AW-1:0]        row_even;
	logic [ROW_AW-1:0]        row_odd;
	logic [2*BANK_MASK_W-1:0] size_mask;
	logic [2*BANK_MASK_W-1:0] mask_win;
	logic [2*BANK_DW-1:0]     data_win;
	logic                     store_en;

	// Byte position inside the doubleword and bank select bit
	assign offset = issue_addr[2:0];
	assign odd    = issue_addr[3];

	// Next doubleword, wraps naturally at the top of the row range
	assign addr_next = issue_addr + XLEN'(8);

	// Even bank holds the upper half of the window when the access starts odd
	assign row_even = odd ? addr_next[4 +: ROW_AW] : issue_addr[4 +: ROW_AW];
	assign row_odd  = issue_addr[4 +: ROW_AW];

	// Byte enables for the access size, before shifting
	always_comb begin
		case (issue_op)
			LSU_SB:  size_mask = 16'h0001;
			LSU_SH:  size_mask = 16'h0003;
			LSU_SW:  size_mask = 16'h000f;
			LSU_SD:  size_mask = 16'h00ff;
			default: size_mask = 16'h0000;
		endcase
	end

	// Place mask and data at the byte offset in a 16-byte window
	assign mask_win = size_mask << offset;
	assign data_win = {{BANK_DW{1'b0}}, issue_wdata} << {offset, 3'b000};

	// Writes only on a valid store
	assign store_en = issue_valid && op_is_store(issue_op);

	// Even bank
	assign banks[0].addr  = row_even;
	assign banks[0].wen   = store_en;
	assign banks[0].wmask = odd ? mask_win[2*BANK_MASK_W-1:BANK_MASK_W]
	                            : mask_win[BANK_MASK_W-1:0];
	assign banks[0].wdata = odd ? data_win[2*BANK_DW-1:BANK_DW]
	                            : data_win[BANK_DW-1:0];

	// Odd bank, halves swapped against the even one
	assign banks[1].addr  = row_odd;
	assign banks[1].wen   = store_en;
	assign banks[1].wmask = odd ? mask_win[BANK_MASK_W-1:0]
	                            : mask_win[2*BANK_MASK_W-1:BANK_MASK_W];
	assign banks[1].wdata = odd ? data_win[BANK_DW-1:0]
	                            : data_win[2*BANK_DW-1:BANK_DW];

endmodule

`default_nettype wire

/* rtl/dtcm_bank_if.sv */
/*
 * DTCM bank port
 * Row address, masked write data and registered read data of one bank
 */
`timescale 1ns/1ns
`default_nettype none

interface dtcm_bank_if #(
	parameter int ROW_AW = 10
) ();
	import lsu_pkg::*;

	// Request side, driven by the steer logic
	logic [ROW_AW-1:0]      addr;
	logic [BANK_DW-1:0]     wdata;
	logic                   wen;
	logic [BANK_MASK_W-1:0] wmask;

	// Registered read data, one cycle after addr
	logic [BANK_DW-1:0]     rdata;

	modport steer (output addr, wdata, wen, wmask);
	modport bank (input addr, wdata, wen, wmask, output rdata);
	modport reader (input rdata);

endinterface

`default_nettype wire

/* rtl/lsu_pkg.sv */
/*
 * Load/store unit shared definitions
 * Memory opcode encoding, data-path widths and bank geometry
 */
`default_nettype none

package lsu_pkg;

	// Data path and tag widths
	localparam int XLEN     = 64;
	// Five register bits plus two rename bits
	localparam int RD_TAG_W = 7;

	// Two banks, even and odd doubleword, fixed by address bit 3
	localparam int BANK_COUNT  = 2;
	localparam int BANK_DW     = 64;
	localparam int BANK_MASK_W = BANK_DW / 8;

	// Memory opcodes
	typedef enum logic [3:0] {
		LSU_NOP,
		LSU_LB,
		LSU_LH,
		LSU_LW,
		LSU_LD,
		LSU_LBU,
		LSU_LHU,
		LSU_LWU,
		LSU_SB,
		LSU_SH,
		LSU_SW,
		LSU_SD
	} lsu_op_e;

	// Store class check
	function automatic logic op_is_store(lsu_op_e op);
		case (op)
			LSU_SB, LSU_SH, LSU_SW, LSU_SD: op_is_store = 1'b1;
			default:                        op_is_store = 1'b0;
		endcase
	endfunction

	// Zero-extending load check
	function automatic logic op_is_unsigned(lsu_op_e op);
		op_is_unsigned = (op == LSU_LBU) || (op == LSU_LHU) || (op == LSU_LWU);
	endfunction

endpackage

`default_nettype wire
